// File: verilog/cache_geom_pkg.sv
// cache geometry package
// address split, line geometry and FSM state codes of the data cache
package cache_geom_pkg;

  localparam int ADDR_BITS = 32;
  localparam int DATA_BITS = 32;
  localparam int ZERO_BITS = 2;
  localparam int WORDS_PER_LINE = 8;
  localparam int LINE_COUNT = 2;
  localparam int BYTES_PER_WORD = DATA_BITS / 8;

  // derived field widths
  localparam int WORD_BITS = $clog2(WORDS_PER_LINE);
  localparam int LINE_BITS = $clog2(LINE_COUNT);
  localparam int TAG_BITS = ADDR_BITS - LINE_BITS - WORD_BITS - ZERO_BITS;

  // address layout |tag|line|word|00|
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [TAG_BITS-1:0] tag_t;
  typedef logic [LINE_BITS-1:0] line_ix_t;
  typedef logic [WORD_BITS-1:0] word_ix_t;
  typedef logic [DATA_BITS-1:0] data_t;
  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;

  // controller states
  localparam int STATE_BITS = 3;
  localparam logic [STATE_BITS-1:0] ST_IDLE = 3'd0;
  localparam logic [STATE_BITS-1:0] ST_ISSUE_WRITE = 3'd1;
  localparam logic [STATE_BITS-1:0] ST_WRITE_BACK = 3'd2;
  localparam logic [STATE_BITS-1:0] ST_ISSUE_READ = 3'd3;
  localparam logic [STATE_BITS-1:0] ST_WAIT_VALID = 3'd4;
  localparam logic [STATE_BITS-1:0] ST_FILL = 3'd5;
  localparam logic [STATE_BITS-1:0] ST_MERGE = 3'd6;

  function automatic tag_t tag_of(addr_t a);
    return a[ADDR_BITS-1 -: TAG_BITS];
  endfunction

  function automatic line_ix_t line_of(addr_t a);
    return a[ZERO_BITS+WORD_BITS +: LINE_BITS];
  endfunction

  function automatic word_ix_t word_of(addr_t a);
    return a[ZERO_BITS +: WORD_BITS];
  endfunction

endpackage

// File: verilog/burst_ram_pkg.sv
// burst RAM package
// beat, mask and address types of the 64-bit burst RAM bus
package burst_ram_pkg;

  localparam int RAM_DATA_BITS = 64;
  localparam int RAM_ADDR_BITS = 8;
  localparam int BURST_BEATS = 4;
  localparam int WORDS_PER_BEAT = RAM_DATA_BITS / cache_geom_pkg::DATA_BITS;
  // byte address to 64-bit word address
  localparam int RAM_SHIFT = cache_geom_pkg::ZERO_BITS + $clog2(WORDS_PER_BEAT);

  typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;
  typedef logic [RAM_DATA_BITS/8-1:0] ram_mask_t;

  localparam ram_mask_t RAM_MASK_ALL = '1;

  // one beat, either raw or as two cache words
  // words[0] holds the even word index
  typedef union packed {
    logic [RAM_DATA_BITS-1:0] raw;
    cache_geom_pkg::data_t [WORDS_PER_BEAT-1:0] words;
  } ram_beat_t;

  // RAM address of the first beat of a line
  function automatic ram_addr_t line_ram_addr(cache_geom_pkg::tag_t tag,
                                              cache_geom_pkg::line_ix_t line);
    cache_geom_pkg::addr_t byte_addr;
    byte_addr = {tag, line, {(cache_geom_pkg::WORD_BITS + cache_geom_pkg::ZERO_BITS){1'b0}}};
    return ram_addr_t'(byte_addr >> RAM_SHIFT);
  endfunction

endpackage

// File: verilog/line_port_if.sv
`timescale 1ns/100ps
// line store port
// word access, byte-merge writes and burst fills between the FSM and the data array
interface line_port_if;
  import cache_geom_pkg::*;
  import burst_ram_pkg::*;

  line_ix_t line_ix;
  word_ix_t word_ix;
  logic wr_strobe;
  byte_en_t wr_bytes;
  data_t wr_data;
  logic fill_strobe;
  // fill data and beat position come from the RAM bus and beat counter
  ram_beat_t fill_beat;
  word_ix_t fill_word_base;
  // requested word is wanted on rd_data
  logic rd_strobe;
  data_t rd_data;
  ram_beat_t wb_beat;
  logic crit_hit;

  modport ctrl (
    output line_ix, word_ix, wr_strobe, wr_bytes, wr_data, fill_strobe, rd_strobe,
    input rd_data, crit_hit
  );

  modport store (
    input line_ix, word_ix, wr_strobe, wr_bytes, wr_data, fill_strobe, fill_beat,
    input fill_word_base, rd_strobe,
    output rd_data, wb_beat, crit_hit
  );

endinterface

// File: verilog/beat_counter.sv
`timescale 1ns/100ps
// burst beat counter
// tracks the beat of the current RAM burst and flags the last one
module beat_counter (
  input  logic clk,
  input  logic rst,
  input  logic clear,
  input  logic advance,
  output logic [1:0] beat_ix,
  output logic last_beat
);
  import burst_ram_pkg::*;

  // clear wins over advance
  always_ff @(posedge clk) begin
    if (rst) begin
      beat_ix <= '0;
    end else if (clear) begin
      beat_ix <= '0;
    end else if (advance) begin
      beat_ix <= beat_ix + 2'd1;
    end
  end

  assign last_beat = (beat_ix == 2'(BURST_BEATS - 1));

  // the FSM must restart the count instead of wrapping past the last beat
  a_no_wrap: assert property (@(posedge clk) disable iff (rst)
    (last_beat && !clear) |-> !advance);

endmodule

// File: verilog/tag_store.sv
`timescale 1ns/100ps
// tag store
// valid, dirty and tag bits per line with the hit compare
module tag_store (
  input  logic clk,
  input  logic rst,
  input  cache_geom_pkg::line_ix_t line_ix,
  input  cache_geom_pkg::tag_t tag,
  input  logic install,
  input  logic set_dirty,
  input  cache_geom_pkg::tag_t new_tag,
  output logic hit,
  output logic victim_dirty,
  output cache_geom_pkg::tag_t victim_tag
);
  import cache_geom_pkg::*;

  logic [LINE_COUNT-1:0] valid;
  logic [LINE_COUNT-1:0] dirty;
  tag_t tags [LINE_COUNT];

  // control bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
      dirty <= '0;
    end else begin
      if (install) begin
        // freshly fetched line is clean
        valid[line_ix] <= 1'b1;
        dirty[line_ix] <= 1'b0;
      end
      if (set_dirty) begin
        dirty[line_ix] <= 1'b1;
      end
    end
  end

  // tag payload
  always_ff @(posedge clk) begin
    if (install) begin
      tags[line_ix] <= new_tag;
    end
  end

  // lookup on the indexed line
  assign hit = valid[line_ix] && (tags[line_ix] == tag);
  // only a valid line can need write-back
  assign victim_dirty = valid[line_ix] && dirty[line_ix];
  assign victim_tag = tags[line_ix];

endmodule

// File: verilog/line_store.sv
`timescale 1ns/100ps
// line data store
// 2 x 8 word array with byte merge, beat fill and beat readout
module line_store (
  input logic clk,
  line_port_if.store line
);
  import cache_geom_pkg::*;
  import burst_ram_pkg::*;

  data_t mem [LINE_COUNT][WORDS_PER_LINE];
  ram_beat_t wb_sel;

  always_ff @(posedge clk) begin
    if (line.wr_strobe) begin
      // merge only the enabled bytes
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (line.wr_bytes[b]) begin
          mem[line.line_ix][line.word_ix][8*b +: 8] <= line.wr_data[8*b +: 8];
        end
      end
    end else if (line.fill_strobe) begin
      // one beat covers two adjacent words
      for (int i = 0; i < WORDS_PER_BEAT; i++) begin
        mem[line.line_ix][word_ix_t'(line.fill_word_base + word_ix_t'(i))]
          <= line.fill_beat.words[i];
      end
    end
  end

  // requested word sits in the beat now arriving
  assign line.crit_hit = line.rd_strobe && line.fill_strobe
                      && ((line.word_ix >> 1) == (line.fill_word_base >> 1));

  // bypass the fill beat so the critical word is not a cycle late
  assign line.rd_data = line.crit_hit ? line.fill_beat.words[line.word_ix[0]]
                                      : mem[line.line_ix][line.word_ix];

  // write-back beat at the current burst position
  always_comb begin
    for (int i = 0; i < WORDS_PER_BEAT; i++) begin
      wb_sel.words[i] = mem[line.line_ix][word_ix_t'(line.fill_word_base + word_ix_t'(i))];
    end
  end

  assign line.wb_beat = wb_sel;

  // merge and fill come from different FSM states
  a_no_wr_fill: assert property (@(posedge clk)
    !(line.wr_strobe && line.fill_strobe));

endmodule

// File: verilog/cache_ctrl_fsm.sv
`timescale 1ns/100ps
// cache controller FSM
// decides hit or miss, sequences write-back and line fill, drives RAM commands
module cache_ctrl_fsm (
  input  logic clk,
  input  logic rst,
  input  logic enable,
  input  logic command,
  input  cache_geom_pkg::addr_t address,
  input  cache_geom_pkg::byte_en_t write_enable_bytes,
  input  cache_geom_pkg::data_t data_in,
  output logic busy,
  output logic data_out_valid,
  output cache_geom_pkg::data_t data_out,
  output logic br_cmd,
  output logic br_cmd_en,
  output burst_ram_pkg::ram_addr_t br_addr,
  input  logic br_rd_data_valid,
  input  logic br_busy,
  input  logic hit,
  input  logic victim_dirty,
  input  cache_geom_pkg::tag_t victim_tag,
  output logic install,
  output logic set_dirty,
  output cache_geom_pkg::tag_t new_tag,
  output logic clear,
  output logic advance,
  input  logic last_beat,
  line_port_if.ctrl line
);
  import cache_geom_pkg::*;
  import burst_ram_pkg::*;

  logic [STATE_BITS-1:0] state;
  logic accept;
  addr_t cur_addr;
  // request held for the whole miss
  logic req_cmd;
  addr_t req_addr;
  byte_en_t req_bytes;
  data_t req_data;

  // new requests only in idle
  assign accept = (state == ST_IDLE) && enable && !busy;

  always_comb begin
    // idle looks at the live request, every other state at the held one
    cur_addr = (state == ST_IDLE) ? address : req_addr;
    line.line_ix = line_of(cur_addr);
    line.word_ix = word_of(cur_addr);
    line.wr_bytes = (state == ST_IDLE) ? write_enable_bytes : req_bytes;
    line.wr_data = (state == ST_IDLE) ? data_in : req_data;
    // write hit merges at once, write miss after the fill
    line.wr_strobe = (accept && command && hit) || (state == ST_MERGE);
    line.fill_strobe = ((state == ST_WAIT_VALID) && br_rd_data_valid) || (state == ST_FILL);
    line.rd_strobe = (state == ST_IDLE) ? (enable && !command) : !req_cmd;

    set_dirty = line.wr_strobe;
    install = (state == ST_ISSUE_READ) && !br_busy;
    new_tag = tag_of(req_addr);

    // counter restarts on a miss and after each burst
    clear = (accept && !hit)
          || (last_beat && ((state == ST_WRITE_BACK) || (state == ST_FILL)));
    advance = ((state == ST_ISSUE_WRITE) && !br_busy)
            || (((state == ST_WRITE_BACK) || line.fill_strobe) && !last_beat);

    // one-cycle command pulse held off by br_busy
    br_cmd_en = ((state == ST_ISSUE_WRITE) || (state == ST_ISSUE_READ)) && !br_busy;
    br_cmd = (state == ST_ISSUE_WRITE);
    if (state == ST_ISSUE_WRITE) begin
      br_addr = line_ram_addr(victim_tag, line_of(req_addr));
    end else begin
      br_addr = line_ram_addr(tag_of(req_addr), line_of(req_addr));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      busy <= 1'b0;
      data_out_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            // only a read hit leaves valid data behind
            data_out_valid <= hit && !command;
            if (!hit) begin
              busy <= 1'b1;
              state <= victim_dirty ? ST_ISSUE_WRITE : ST_ISSUE_READ;
            end
          end
        end
        ST_ISSUE_WRITE: begin
          // beat 0 goes out with the command
          if (!br_busy) begin
            state <= ST_WRITE_BACK;
          end
        end
        ST_WRITE_BACK: begin
          if (last_beat) begin
            state <= ST_ISSUE_READ;
          end
        end
        ST_ISSUE_READ: begin
          if (!br_busy) begin
            state <= ST_WAIT_VALID;
          end
        end
        ST_WAIT_VALID: begin
          if (br_rd_data_valid) begin
            state <= ST_FILL;
          end
        end
        ST_FILL: begin
          if (last_beat) begin
            if (req_cmd) begin
              state <= ST_MERGE;
            end else begin
              busy <= 1'b0;
              state <= ST_IDLE;
            end
          end
        end
        ST_MERGE: begin
          busy <= 1'b0;
          state <= ST_IDLE;
        end
        default: begin
          busy <= 1'b0;
          state <= ST_IDLE;
        end
      endcase
      // requested word seen in the incoming beat
      if (line.crit_hit) begin
        data_out_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_cmd <= command;
      req_addr <= address;
      req_bytes <= write_enable_bytes;
      req_data <= data_in;
    end
    // read hit word, or critical word bypassed from the fill
    if ((accept && hit && !command) || line.crit_hit) begin
      data_out <= line.rd_data;
    end
  end

  // a RAM command lasts a single cycle
  a_cmd_pulse: assert property (@(posedge clk) disable iff (rst)
    br_cmd_en |=> !br_cmd_en);

  // busy always drops by the time the FSM is back in idle
  a_idle_not_busy: assert property (@(posedge clk) disable iff (rst)
    (state == ST_IDLE) |-> !busy);

endmodule

// File: verilog/data_cache.sv
`timescale 1ns/100ps
// direct-mapped write-back data cache
// two lines of eight words in front of a 64-bit burst RAM
module data_cache (
  input  logic clk,
  input  logic rst,
  input  logic enable,
  input  logic command,
  input  cache_geom_pkg::addr_t address,
  input  cache_geom_pkg::byte_en_t write_enable_bytes,
  input  cache_geom_pkg::data_t data_in,
  output cache_geom_pkg::data_t data_out,
  output logic data_out_valid,
  output logic busy,
  output logic br_cmd,
  output logic br_cmd_en,
  output burst_ram_pkg::ram_addr_t br_addr,
  output logic [burst_ram_pkg::RAM_DATA_BITS-1:0] br_wr_data,
  output burst_ram_pkg::ram_mask_t br_data_mask,
  input  logic [burst_ram_pkg::RAM_DATA_BITS-1:0] br_rd_data,
  input  logic br_rd_data_valid,
  input  logic br_busy
);
  import cache_geom_pkg::*;
  import burst_ram_pkg::*;

  logic hit;
  logic victim_dirty;
  tag_t victim_tag;
  logic install;
  logic set_dirty;
  tag_t new_tag;
  logic clear;
  logic advance;
  logic [1:0] beat_ix;
  logic last_beat;

  line_port_if line_if ();

  // RAM side of the line port
  assign line_if.fill_beat.raw = br_rd_data;
  assign line_if.fill_word_base = word_ix_t'({beat_ix, 1'b0});
  assign br_wr_data = line_if.wb_beat.raw;
  // whole beats only
  assign br_data_mask = RAM_MASK_ALL;

  cache_ctrl_fsm u_fsm (
    .clk(clk), .rst(rst),
    .enable(enable), .command(command), .address(address),
    .write_enable_bytes(write_enable_bytes), .data_in(data_in),
    .busy(busy), .data_out_valid(data_out_valid), .data_out(data_out),
    .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy),
    .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .install(install), .set_dirty(set_dirty), .new_tag(new_tag),
    .clear(clear), .advance(advance), .last_beat(last_beat),
    .line(line_if.ctrl)
  );

  beat_counter u_beats (
    .clk(clk), .rst(rst), .clear(clear), .advance(advance),
    .beat_ix(beat_ix), .last_beat(last_beat)
  );

  // lookup tag always from the live address, hit only matters in idle
  tag_store u_tags (
    .clk(clk), .rst(rst), .line_ix(line_if.line_ix), .tag(tag_of(address)),
    .install(install), .set_dirty(set_dirty), .new_tag(new_tag),
    .hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
  );

  line_store u_lines (
    .clk(clk),
    .line(line_if.store)
  );

endmodule

// File: tests/burst_ram_model.sv
`timescale 1ns/100ps
// burst RAM model
// 2 KB of 64-bit words, 4-beat bursts, read beats 2 cycles after the command
module burst_ram_model (
  input  logic clk,
  input  logic rst,
  input  logic br_cmd,
  input  logic br_cmd_en,
  input  burst_ram_pkg::ram_addr_t br_addr,
  input  logic [burst_ram_pkg::RAM_DATA_BITS-1:0] br_wr_data,
  input  burst_ram_pkg::ram_mask_t br_data_mask,
  output logic [burst_ram_pkg::RAM_DATA_BITS-1:0] br_rd_data,
  output logic br_rd_data_valid,
  output logic br_busy
);
  import burst_ram_pkg::*;

  localparam int READ_DELAY = 2;

  ram_beat_t mem [2 ** RAM_ADDR_BITS];
  ram_addr_t rd_ptr;
  ram_addr_t wr_ptr;
  int rd_wait;
  int rd_left;
  int wr_left;
  // command log, read by the testbench
  int rd_cmds;
  int wr_cmds;
  int wr_beat_cnt;
  int mask_errs;
  ram_addr_t last_rd_addr;
  ram_addr_t last_wr_addr;
  ram_beat_t wr_beats [BURST_BEATS];

  // preload one 64-bit word
  task automatic load_beat(input ram_addr_t a, input ram_beat_t beat);
    mem[a] = beat;
  endtask

  initial begin
    br_rd_data <= '0;
    br_rd_data_valid <= 1'b0;
    br_busy <= 1'b0;
  end

  always @(posedge clk) begin
    if (rst) begin
      br_rd_data_valid <= 1'b0;
      br_busy <= 1'b0;
      rd_left <= 0;
      wr_left <= 0;
      rd_cmds <= 0;
      wr_cmds <= 0;
      wr_beat_cnt <= 0;
      mask_errs <= 0;
    end else begin
      // one busy cycle after every command
      br_busy <= br_cmd_en;
      br_rd_data_valid <= 1'b0;
      // read burst, beats on consecutive cycles once the delay ran out
      if (rd_left > 0) begin
        if (rd_wait > 0) begin
          rd_wait <= rd_wait - 1;
        end else begin
          br_rd_data <= mem[rd_ptr].raw;
          br_rd_data_valid <= 1'b1;
          rd_ptr <= rd_ptr + 1'b1;
          rd_left <= rd_left - 1;
        end
      end
      // beats 1 to 3 follow the write command back to back
      if (wr_left > 0) begin
        mem[wr_ptr].raw = br_wr_data;
        wr_beats[wr_beat_cnt].raw <= br_wr_data;
        wr_beat_cnt <= wr_beat_cnt + 1;
        wr_ptr <= wr_ptr + 1'b1;
        wr_left <= wr_left - 1;
      end
      if (br_cmd_en) begin
        if (br_cmd) begin
          // beat 0 rides with the command
          mem[br_addr].raw = br_wr_data;
          wr_beats[0].raw <= br_wr_data;
          wr_beat_cnt <= 1;
          wr_ptr <= br_addr + 1'b1;
          wr_left <= BURST_BEATS - 1;
          wr_cmds <= wr_cmds + 1;
          last_wr_addr <= br_addr;
          if (br_data_mask != RAM_MASK_ALL) begin
            mask_errs <= mask_errs + 1;
          end
        end else begin
          rd_ptr <= br_addr;
          rd_wait <= READ_DELAY - 1;
          rd_left <= BURST_BEATS;
          rd_cmds <= rd_cmds + 1;
          last_rd_addr <= br_addr;
        end
      end
    end
  end

endmodule

// File: tests/tb_data_cache.sv
`timescale 1ns/100ps
// data cache testbench
// table of requests checked against a shadow copy of the RAM contents
module tb_data_cache;
  import cache_geom_pkg::*;
  import burst_ram_pkg::*;

  localparam int OP_COUNT = 10;
  localparam int WAIT_LIMIT = 50;

  // one request and the RAM traffic it should cause
  typedef struct {
    logic cmd;
    addr_t addr;
    byte_en_t bytes;
    data_t data;
    int n_rd;
    int n_wr;
    addr_t wb_base;
  } op_t;

  logic clk;
  logic rst;
  logic enable;
  logic command;
  addr_t address;
  byte_en_t write_enable_bytes;
  data_t data_in;
  data_t data_out;
  logic data_out_valid;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  ram_addr_t br_addr;
  logic [RAM_DATA_BITS-1:0] br_wr_data;
  ram_mask_t br_data_mask;
  logic [RAM_DATA_BITS-1:0] br_rd_data;
  logic br_rd_data_valid;
  logic br_busy;

  // word view of the whole 2 KB RAM
  data_t shadow [2 * (2 ** RAM_ADDR_BITS)];
  op_t ops [OP_COUNT];
  int data_errs;
  int flag_errs;
  int beat_errs;
  int ram_errs;
  int wait_errs;

  data_cache UUT (.*);

  burst_ram_model ram (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_data(input string name, input data_t got, input data_t want);
    if (got !== want) begin
      $display("error %s got %h expected %h", name, got, want);
      data_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("error %s got %h expected %h", name, got, want);
      flag_errs++;
    end
  endtask

  task automatic check_beat(input string name, input ram_beat_t got, input ram_beat_t want);
    if (got.raw !== want.raw) begin
      $display("error %s got %h expected %h", name, got.raw, want.raw);
      beat_errs++;
    end
  endtask

  task automatic check_addr(input string name, input ram_addr_t got, input ram_addr_t want);
    if (got !== want) begin
      $display("error %s got %h expected %h", name, got, want);
      ram_errs++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int want);
    if (got != want) begin
      $display("error %s got %h expected %h", name, got, want);
      ram_errs++;
    end
  endtask

  // RAM address of the first beat of the line holding a byte address
  function automatic ram_addr_t line_base(addr_t a);
    return {a[10:5], 2'b00};
  endfunction

  function automatic data_t merge_bytes(data_t old_word, data_t new_word, byte_en_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < BYTES_PER_WORD; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  task automatic preload_ram();
    ram_beat_t beat;
    for (int a = 0; a < 2 ** RAM_ADDR_BITS; a++) begin
      beat.words[0] = $urandom;
      beat.words[1] = $urandom;
      // lower half is the even word
      shadow[2*a] = beat.words[0];
      shadow[2*a + 1] = beat.words[1];
      ram.load_beat(ram_addr_t'(a), beat);
    end
  endtask

  task automatic load_table();
    // cmd, address, byte enables, data, RAM reads, RAM writes, evicted line
    // line 0: clean miss, hit, write hit, hit on the merged word
    ops[0] = '{1'b0, 32'h0000_0048, 4'h0, 32'h0, 1, 0, 32'h0};
    ops[1] = '{1'b0, 32'h0000_005C, 4'h0, 32'h0, 0, 0, 32'h0};
    ops[2] = '{1'b1, 32'h0000_004C, 4'b0101, 32'hA5C3_5A3C, 0, 0, 32'h0};
    ops[3] = '{1'b0, 32'h0000_004C, 4'h0, 32'h0, 0, 0, 32'h0};
    // conflicting tag evicts the dirty line, then the old address again
    ops[4] = '{1'b0, 32'h0000_00C8, 4'h0, 32'h0, 1, 1, 32'h0000_0040};
    ops[5] = '{1'b0, 32'h0000_004C, 4'h0, 32'h0, 1, 0, 32'h0};
    // line 1: write miss, hit, eviction, reload
    ops[6] = '{1'b1, 32'h0000_03A4, 4'b1100, 32'h1234_ABCD, 1, 0, 32'h0};
    ops[7] = '{1'b0, 32'h0000_03A4, 4'h0, 32'h0, 0, 0, 32'h0};
    ops[8] = '{1'b0, 32'h0000_07A0, 4'h0, 32'h0, 1, 1, 32'h0000_03A0};
    ops[9] = '{1'b0, 32'h0000_03A4, 4'h0, 32'h0, 1, 0, 32'h0};
  endtask

  // one cycle at a time, for busy low or for data_out_valid high
  task automatic wait_until(input int n, input bit for_valid);
    int cycles;
    cycles = 0;
    while ((for_valid ? !data_out_valid : busy) && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (for_valid ? !data_out_valid : busy) begin
      $display("timeout in operation %0d waiting for %s", n,
               for_valid ? "data_out_valid to rise" : "busy to fall");
      wait_errs++;
    end
  endtask

  task automatic apply_op(input int n);
    int rd_before;
    int wr_before;
    int wb_ix;
    data_t want;
    ram_beat_t want_beat;
    rd_before = ram.rd_cmds;
    wr_before = ram.wr_cmds;
    want = shadow[ops[n].addr[10:2]];
    enable = 1'b1;
    command = ops[n].cmd;
    address = ops[n].addr;
    write_enable_bytes = ops[n].bytes;
    data_in = ops[n].data;
    @(posedge clk);
    #1;
    enable = 1'b0;
    if (ops[n].n_rd == 0) begin
      // a hit completes at the accepting edge, busy never rises
      check_flag("busy", busy, 1'b0);
      @(posedge clk);
      #1;
      check_flag("busy", busy, 1'b0);
    end else begin
      check_flag("busy", busy, 1'b1);
      check_flag("data_out_valid", data_out_valid, 1'b0);
      wait_until(n, 1'b0);
      if (!ops[n].cmd) begin
        wait_until(n, 1'b1);
      end
    end
    check_flag("data_out_valid", data_out_valid, !ops[n].cmd);
    if (!ops[n].cmd) begin
      check_data("data_out", data_out, want);
    end
    check_count("read commands", ram.rd_cmds - rd_before, ops[n].n_rd);
    check_count("write commands", ram.wr_cmds - wr_before, ops[n].n_wr);
    if (ops[n].n_rd != 0) begin
      check_addr("br_addr of read", ram.last_rd_addr, line_base(ops[n].addr));
    end
    if (ops[n].n_wr != 0) begin
      check_addr("br_addr of write", ram.last_wr_addr, line_base(ops[n].wb_base));
      check_count("write beats", ram.wr_beat_cnt, BURST_BEATS);
      check_count("br_data_mask faults", ram.mask_errs, 0);
      // evicted line as the shadow holds it
      for (int i = 0; i < BURST_BEATS; i++) begin
        wb_ix = int'(ops[n].wb_base[10:2]) + 2 * i;
        want_beat.words[0] = shadow[wb_ix];
        want_beat.words[1] = shadow[wb_ix + 1];
        check_beat("br_wr_data", ram.wr_beats[i], want_beat);
      end
    end
    if (ops[n].cmd) begin
      shadow[ops[n].addr[10:2]] = merge_bytes(want, ops[n].data, ops[n].bytes);
    end
  endtask

  initial begin
    void'($urandom(42));
    rst = 1'b1;
    enable = 1'b0;
    command = 1'b0;
    address = '0;
    write_enable_bytes = '0;
    data_in = '0;
    data_errs = 0;
    flag_errs = 0;
    beat_errs = 0;
    ram_errs = 0;
    wait_errs = 0;
    preload_ram();
    load_table();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // state right after reset
    check_flag("busy", busy, 1'b0);
    check_flag("data_out_valid", data_out_valid, 1'b0);
    check_flag("br_cmd_en", br_cmd_en, 1'b0);
    for (int i = 0; i < OP_COUNT; i++) begin
      apply_op(i);
    end
    $display("errors: data %0d, flag %0d, beat %0d, ram %0d, timeout %0d",
             data_errs, flag_errs, beat_errs, ram_errs, wait_errs);
    if (data_errs + flag_errs + beat_errs + ram_errs + wait_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
verilog/cache_geom_pkg.sv
verilog/burst_ram_pkg.sv
verilog/line_port_if.sv
verilog/beat_counter.sv
verilog/tag_store.sv
verilog/line_store.sv
verilog/cache_ctrl_fsm.sv
verilog/data_cache.sv
tests/burst_ram_model.sv
tests/tb_data_cache.sv

// File: Makefile
TOP := tb_data_cache

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only --timing --assert --top-module data_cache -f compile.f

clean:
	rm -rf obj_dir
